//--- Makefile
TOOL       := verilator
FLIST      := maskedSbox.f
TOP        := tbMaskedSbox
OBJ_DIR    := obj_dir
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing --assert -j 0
PASS_MSG   := >>> PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

sim:
	$(TOOL) $(SIM_FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)

//--- design/basisChange.sv
`include "maskedSbox_consts.svh"

module basisChange #(
    parameter bit toTower = 1'b1
) (
    input  maskedSboxPkg::shareByte_t in,
    output maskedSboxPkg::shareByte_t out
);
    import maskedSboxPkg::*;

    // Column b is the image of input bit b.
    // Tower columns are the powers beta^b with beta = z*Y, a root of the
    // AES polynomial x^8 + x^4 + x^3 + x + 1 in GF((2^4)^2)
    localparam gf8_t towerCols [8] = '{
        8'h01, 8'h20, 8'h46, 8'h4C,
        8'h3C, 8'hD5, 8'h34, 8'hE5
    };

    // Inverse basis change followed by the AES affine matrix
    localparam gf8_t aesCols [8] = '{
        8'h1F, 8'hB2, 8'hAB, 8'h36,
        8'h52, 8'h3E, 8'h65, 8'h60
    };

    gf8_t col;

    // Linear map, so each share goes through the same matrix
    always_comb begin
        out = '0;
        col = '0;
        for (int s = 0; s < `MS_SHARES; s++) begin
            for (int b = 0; b < 8; b++) begin
                col = toTower ? towerCols[b] : aesCols[b];
                if (in[s][b]) begin
                    out[s] = out[s] ^ col;
                end
            end
        end
    end

endmodule

//--- design/domInvGf4.sv
`include "maskedSbox_consts.svh"

module domInvGf4 (
    input  logic                     ClkxCI,
    input  logic                     en,
    input  maskedSboxPkg::shareGf4_t x,
    input  maskedSboxPkg::mulRand_t  zA,
    input  maskedSboxPkg::mulRand_t  zB,
    output maskedSboxPkg::shareGf4_t xInv
);
    import maskedSboxPkg::*;

    shareGf4_t x2;
    shareGf4_t x4;
    shareGf4_t x8;
    shareGf4_t x8Q;
    shareGf4_t x6;

    // Frobenius powers, linear per share
    always_comb begin
        for (int i = 0; i < `MS_SHARES; i++) begin
            x2[i] = gf4Sq(x[i]);
            x4[i] = gf4Sq(x2[i]);
            x8[i] = gf4Sq(x4[i]);
        end
    end

    // x^8 travels beside stage A to meet x^6 in stage B
    always_ff @(posedge ClkxCI) begin
        if (en) begin
            x8Q <= x8;
        end
    end

    // Stage A, x^6 = x^2 * x^4
    domMulGf4 #(
        .shares(`MS_SHARES)
    ) mulA (
        .ClkxCI(ClkxCI),
        .en    (en),
        .a     (x2),
        .b     (x4),
        .z     (zA),
        .q     (x6)
    );

    // Stage B, x^14 = x^6 * x^8, and 0 maps to 0
    domMulGf4 #(
        .shares(`MS_SHARES)
    ) mulB (
        .ClkxCI(ClkxCI),
        .en    (en),
        .a     (x6),
        .b     (x8Q),
        .z     (zB),
        .q     (xInv)
    );

endmodule

//--- design/domMulGf4.sv
`include "maskedSbox_consts.svh"

module domMulGf4 #(
    parameter int shares = `MS_SHARES
) (
    input  logic                     ClkxCI,
    input  logic                     en,
    input  maskedSboxPkg::shareGf4_t a,
    input  maskedSboxPkg::shareGf4_t b,
    input  maskedSboxPkg::mulRand_t  z,
    output maskedSboxPkg::shareGf4_t q
);
    import maskedSboxPkg::*;

    // Row i collects the terms of domain i, diagonal is the inner product
    gf4_t termQ [shares][shares];

    // Nibble index of the unordered pair {i, j}
    function automatic int pairIdx(input int i, input int j);
        int lo;
        int hi;
        lo = (i < j) ? i : j;
        hi = (i < j) ? j : i;
        return lo * shares - lo * (lo + 1) / 2 + hi - lo - 1;
    endfunction

    // Cross terms (i,j) and (j,i) share one blinding nibble,
    // which cancels when both domains are recombined
    always_ff @(posedge ClkxCI) begin
        if (en) begin
            for (int i = 0; i < shares; i++) begin
                for (int j = 0; j < shares; j++) begin
                    if (i == j) begin
                        termQ[i][j] <= gf4Mul(a[i], b[i]);
                    end else begin
                        termQ[i][j] <= gf4Mul(a[i], b[j]) ^ z[4*pairIdx(i, j) +: 4];
                    end
                end
            end
        end
    end

    // Compression after the register stage
    always_comb begin
        q = '0;
        for (int i = 0; i < shares; i++) begin
            for (int j = 0; j < shares; j++) begin
                q[i] = q[i] ^ termQ[i][j];
            end
        end
    end

endmodule

//--- design/maskedSboxCore.sv
`include "maskedSbox_consts.svh"

module maskedSboxCore (
    input  logic                      ClkxCI,
    input  logic                      rstN,
    input  logic                      advance,
    input  logic                      inValid,
    input  maskedSboxPkg::sboxIn_t    inData,
    input  maskedSboxPkg::sboxRand_t  freshRand,
    output logic                      outValid,
    output maskedSboxPkg::sboxOut_t   outData
);
    import maskedSboxPkg::*;

    // y values wait here until the inverse is ready
    localparam int delayDepth = 3;

    mulRand_t zDelta;
    mulRand_t zInvA;
    mulRand_t zInvB;
    mulRand_t zMsb;
    mulRand_t zLsb;

    shareByte_t mapped;
    shareByte_t stage1Q;
    shareByte_t yDelayQ [delayDepth];
    shareByte_t towerOut;
    shareByte_t aesOut;

    shareGf4_t y1;
    shareGf4_t y0;
    shareGf4_t linTerm;
    shareGf4_t linQ;
    shareGf4_t deltaMul;
    shareGf4_t delta;
    shareGf4_t deltaInv;
    shareGf4_t dY1;
    shareGf4_t dY0;
    shareGf4_t dSum;
    shareGf4_t msb;
    shareGf4_t lsb;

    logic [`MS_LATENCY-1:0] validQ;

    // One randomness field per multiplier, in pipeline order
    assign zDelta = freshRand[0*`MS_RAND_PER_MUL +: `MS_RAND_PER_MUL];
    assign zInvA  = freshRand[1*`MS_RAND_PER_MUL +: `MS_RAND_PER_MUL];
    assign zInvB  = freshRand[2*`MS_RAND_PER_MUL +: `MS_RAND_PER_MUL];
    assign zMsb   = freshRand[3*`MS_RAND_PER_MUL +: `MS_RAND_PER_MUL];
    assign zLsb   = freshRand[4*`MS_RAND_PER_MUL +: `MS_RAND_PER_MUL];

    basisChange #(
        .toTower(1'b1)
    ) inMap (
        .in (inData.shares),
        .out(mapped)
    );

    always_ff @(posedge ClkxCI) begin
        if (advance) begin
            stage1Q <= mapped;
            linQ <= linTerm;
            yDelayQ[0] <= stage1Q;
            for (int d = 1; d < delayDepth; d++) begin
                yDelayQ[d] <= yDelayQ[d-1];
            end
        end
    end

    // Nibble split and the linear part of Delta
    always_comb begin
        for (int i = 0; i < `MS_SHARES; i++) begin
            y1[i] = stage1Q[i][7:4];
            y0[i] = stage1Q[i][3:0];
            linTerm[i] = gf4SqScale(y1[i]) ^ gf4Sq(y0[i]);
            dY1[i] = yDelayQ[delayDepth-1][i][7:4];
            dY0[i] = yDelayQ[delayDepth-1][i][3:0];
            dSum[i] = dY1[i] ^ dY0[i];
            towerOut[i] = {msb[i], lsb[i]};
        end
    end

    domMulGf4 mulDelta (
        .ClkxCI(ClkxCI),
        .en    (advance),
        .a     (y1),
        .b     (y0),
        .z     (zDelta),
        .q     (deltaMul)
    );

    // Delta = lambda*y1^2 + y1*y0 + y0^2
    assign delta = deltaMul ^ linQ;

    domInvGf4 inv (
        .ClkxCI(ClkxCI),
        .en    (advance),
        .x     (delta),
        .zA    (zInvA),
        .zB    (zInvB),
        .xInv  (deltaInv)
    );

    // High nibble of the inverse
    domMulGf4 mulMsb (
        .ClkxCI(ClkxCI),
        .en    (advance),
        .a     (dY1),
        .b     (deltaInv),
        .z     (zMsb),
        .q     (msb)
    );

    // Low nibble uses y0 + y1
    domMulGf4 mulLsb (
        .ClkxCI(ClkxCI),
        .en    (advance),
        .a     (dSum),
        .b     (deltaInv),
        .z     (zLsb),
        .q     (lsb)
    );

    basisChange #(
        .toTower(1'b0)
    ) outMap (
        .in (towerOut),
        .out(aesOut)
    );

    // Affine constant enters share 0 only
    always_comb begin
        outData.shares = aesOut;
        outData.shares[0] = aesOut[0] ^ `MS_AFFINE_C;
    end

    always_ff @(posedge ClkxCI) begin
        if (!rstN) begin
            validQ <= '0;
        end else if (advance) begin
            validQ <= {validQ[`MS_LATENCY-2:0], inValid};
        end
    end

    assign outValid = validQ[`MS_LATENCY-1];

    validKnown: assert property (@(posedge ClkxCI) disable iff (!rstN)
        !$isunknown(outValid))
        else $error("outValid unknown after reset");

    // A stalled result must hold until taken
    holdOnStall: assert property (@(posedge ClkxCI) disable iff (!rstN)
        outValid && !advance |=> $stable(outData))
        else $error("outData changed while stalled");

endmodule

//--- design/maskedSboxPkg.sv
`include "maskedSbox_consts.svh"

package maskedSboxPkg;

    // Field elements
    typedef logic [3:0] gf4_t;
    typedef logic [7:0] gf8_t;

    // Fresh randomness
    typedef logic [`MS_RAND_PER_MUL-1:0] mulRand_t;
    typedef logic [`MS_RAND_W-1:0] sboxRand_t;

    // Share vectors, index 0 is share 0
    typedef gf4_t [`MS_SHARES-1:0] shareGf4_t;
    typedef gf8_t [`MS_SHARES-1:0] shareByte_t;

    typedef struct packed {
        shareByte_t shares;
    } sboxIn_t;

    typedef struct packed {
        shareByte_t shares;
    } sboxOut_t;

    // Plain product in GF(2^4) modulo z^4 + z + 1
    function automatic gf4_t gf4Mul(input gf4_t a, input gf4_t b);
        gf4_t acc;
        gf4_t t;
        acc = '0;
        t = a;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                acc = acc ^ t;
            end
            t = {t[2:0], 1'b0} ^ (t[3] ? `MS_GF4_REDUCE : 4'h0);
        end
        return acc;
    endfunction

    // Squaring is GF(2)-linear, so it is applied to each share on its own
    function automatic gf4_t gf4Sq(input gf4_t a);
        return {a[3], a[1] ^ a[3], a[2], a[0] ^ a[2]};
    endfunction

    function automatic gf4_t gf4SqScale(input gf4_t a);
        return gf4Mul(`MS_LAMBDA, gf4Sq(a));
    endfunction

endpackage

//--- design/maskedSboxTop.sv
module maskedSboxTop (
    input  logic                      ClkxCI,
    input  logic                      rstN,
    input  logic                      inValid,
    output logic                      inReady,
    input  maskedSboxPkg::sboxIn_t    inData,
    input  maskedSboxPkg::sboxRand_t  freshRand,
    output logic                      outValid,
    input  logic                      outReady,
    output maskedSboxPkg::sboxOut_t   outData
);

    logic advance;

    // Global stall, the whole pipeline moves when the output slot frees up
    assign advance = outReady | ~outValid;
    assign inReady = advance;

    maskedSboxCore core_i (
        .ClkxCI   (ClkxCI),
        .rstN     (rstN),
        .advance  (advance),
        .inValid  (inValid),
        .inData   (inData),
        .freshRand(freshRand),
        .outValid (outValid),
        .outData  (outData)
    );

endmodule

//--- design/maskedSbox_consts.svh
`ifndef MASKED_SBOX_CONSTS_SVH
`define MASKED_SBOX_CONSTS_SVH

// Boolean shares per byte, first order needs two
`define MS_SHARES 2
// Register stages from input map to output multipliers
`define MS_LATENCY 5
// Low terms of z^4 + z + 1, the GF(2^4) modulus
`define MS_GF4_REDUCE 4'h3
// lambda = z^3 has trace 1, so Y^2 + Y + lambda is irreducible
`define MS_LAMBDA 4'h8
`define MS_AFFINE_C 8'h63
// One nibble per share pair
`define MS_RAND_PER_MUL (4 * `MS_SHARES * (`MS_SHARES - 1) / 2)
`define MS_NUM_MUL 5
`define MS_RAND_W (`MS_RAND_PER_MUL * `MS_NUM_MUL)

`endif

//--- maskedSbox.f
+incdir+design
+incdir+verif
design/maskedSboxPkg.sv
design/basisChange.sv
design/domMulGf4.sv
design/domInvGf4.sv
design/maskedSboxCore.sv
design/maskedSboxTop.sv
verif/tbMaskedSbox.sv

//--- verif/tbSboxModel.svh
`ifndef TB_SBOX_MODEL_SVH
`define TB_SBOX_MODEL_SVH

// Product in GF(2^8) modulo the AES polynomial 0x11B
function automatic gf8_t gf8Times(input gf8_t a, input gf8_t b);
    gf8_t acc;
    gf8_t t;
    acc = '0;
    t = a;
    for (int i = 0; i < 8; i++) begin
        if (b[i]) begin
            acc = acc ^ t;
        end
        t = {t[6:0], 1'b0} ^ (t[7] ? 8'h1B : 8'h00);
    end
    return acc;
endfunction

// a^254 by square and multiply, bits 1 to 7 of the exponent are set
function automatic gf8_t gf8Inverse(input gf8_t a);
    gf8_t r;
    gf8_t p;
    r = 8'h01;
    p = a;
    for (int i = 0; i < 8; i++) begin
        if (i != 0) begin
            r = gf8Times(r, p);
        end
        p = gf8Times(p, p);
    end
    return r;
endfunction

// AES affine step, bit i sees bits i, i+4 .. i+7 and the constant 0x63
function automatic gf8_t affineMap(input gf8_t b);
    gf8_t r;
    for (int i = 0; i < 8; i++) begin
        r[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8] ^ b[(i + 7) % 8];
    end
    return r ^ 8'h63;
endfunction

function automatic gf8_t sboxRef(input gf8_t x);
    return affineMap(gf8Inverse(x));
endfunction

// Unmasked value of a shared byte
function automatic gf8_t recombine(input shareByte_t s);
    gf8_t r;
    r = '0;
    for (int i = 0; i < `MS_SHARES; i++) begin
        r = r ^ s[i];
    end
    return r;
endfunction

`endif

//--- verif/tbMaskedSbox.sv
`include "maskedSbox_consts.svh"

module tbMaskedSbox;
    timeunit 1ns;
    timeprecision 1ps;

    import maskedSboxPkg::*;

`include "tbSboxModel.svh"

    localparam int seed = 32'h5734f1aa;
    localparam int burstCount = 16;
    localparam int bpCount = 1100;
    // Stalls stretch each back-pressure item to roughly four cycles
    localparam int cycleLimit = 4 * (256 + 32 * 8 + burstCount + 4 * bpCount + 100);

    logic ClkxCI;
    logic rstN;
    logic inValid;
    logic inReady;
    sboxIn_t inData;
    sboxRand_t freshRand;
    logic outValid;
    logic outReady;
    sboxOut_t outData;

    logic randomReady;
    logic strictLatency;
    logic burstMode;
    logic holdPending;
    logic prevRstN;
    gf8_t curX;
    sboxOut_t heldData;
    gf8_t expQ[$];
    int acceptQ[$];
    int cycle;
    int lastOutCycle;
    int burstOuts;
    int valueErrors;
    int protocolErrors;

    maskedSboxTop dut_i (
        .ClkxCI   (ClkxCI),
        .rstN     (rstN),
        .inValid  (inValid),
        .inReady  (inReady),
        .inData   (inData),
        .freshRand(freshRand),
        .outValid (outValid),
        .outReady (outReady),
        .outData  (outData)
    );

    initial begin
        ClkxCI = 1'b0;
        forever #5 ClkxCI = ~ClkxCI;
    end

    task automatic checkBit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            valueErrors++;
        end
    endtask

    task automatic checkByte(input string name, input gf8_t actual, input gf8_t expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            valueErrors++;
        end
    endtask

    task automatic checkCount(input string name, input int actual, input int expected);
        if (actual != expected) begin
            $display("Fail %s: got %0h, expected %0h", name, actual, expected);
            valueErrors++;
        end
    endtask

    // Share 0 absorbs the other shares so they recombine to x
    function automatic sboxIn_t maskByte(input gf8_t x);
        sboxIn_t m;
        m.shares[0] = x;
        for (int s = 1; s < `MS_SHARES; s++) begin
            m.shares[s] = gf8_t'($urandom());
            m.shares[0] = m.shares[0] ^ m.shares[s];
        end
        return m;
    endfunction

    function automatic sboxRand_t randomBits();
        sboxRand_t r;
        for (int i = 0; i < `MS_RAND_W; i++) begin
            r[i] = 1'($urandom());
        end
        return r;
    endfunction

    // New randomness and ready on every falling edge
    task automatic nextCycle();
        @(negedge ClkxCI);
        freshRand = randomBits();
        outReady = randomReady ? ($urandom_range(99) < 40) : 1'b1;
    endtask

    task automatic sendByte(input gf8_t x);
        logic taken;
        curX = x;
        inData = maskByte(x);
        inValid = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(posedge ClkxCI);
            taken = inReady;
            nextCycle();
        end
        inValid = 1'b0;
    endtask

    task automatic drain();
        inValid = 1'b0;
        while (expQ.size() != 0) begin
            nextCycle();
        end
    endtask

    task automatic takeResult();
        gf8_t x;
        int t0;
        if (expQ.size() == 0) begin
            $display("Extra result on outData with no input pending at cycle %0d", cycle);
            protocolErrors++;
        end else begin
            x = expQ.pop_front();
            t0 = acceptQ.pop_front();
            checkByte("outData", recombine(outData.shares), sboxRef(x));
            if (strictLatency) begin
                checkCount("latency", cycle - t0, `MS_LATENCY);
            end
            if (burstMode) begin
                if (burstOuts > 0) begin
                    checkCount("result spacing", cycle - lastOutCycle, 1);
                end
                lastOutCycle = cycle;
                burstOuts++;
            end
        end
    endtask

    // Compare process, all values sampled before the edge updates them
    always @(posedge ClkxCI) begin
        cycle = cycle + 1;
        if (cycle >= cycleLimit) begin
            $display("Timeout, the run did not finish within %0d cycles", cycleLimit);
            $display(">>> FAIL");
            $finish;
        end else if (!rstN) begin
            // Valid bits are unknown until the first reset edge
            if (cycle > 1) begin
                checkBit("outValid", outValid, 1'b0);
                checkBit("inReady", inReady, 1'b1);
            end
            prevRstN = 1'b0;
        end else begin
            if (!prevRstN) begin
                checkBit("outValid", outValid, 1'b0);
            end
            prevRstN = 1'b1;
            checkBit("inReady", inReady, !(outValid && !outReady));
            if (holdPending) begin
                checkBit("outValid", outValid, 1'b1);
                for (int s = 0; s < `MS_SHARES; s++) begin
                    checkByte($sformatf("outData.shares[%0d]", s), outData.shares[s],
                        heldData.shares[s]);
                end
            end
            holdPending = outValid && !outReady;
            heldData = outData;
            if (outValid && outReady) begin
                takeResult();
            end
            if (inValid && inReady) begin
                expQ.push_back(curX);
                acceptQ.push_back(cycle);
            end
        end
    end

    initial begin
        gf8_t x;
        void'($urandom(seed));
        rstN = 1'b0;
        inValid = 1'b0;
        inData = '0;
        freshRand = '0;
        outReady = 1'b1;
        randomReady = 1'b0;
        strictLatency = 1'b0;
        burstMode = 1'b0;
        holdPending = 1'b0;
        prevRstN = 1'b0;
        curX = '0;
        heldData = '0;
        cycle = 0;
        lastOutCycle = 0;
        burstOuts = 0;
        valueErrors = 0;
        protocolErrors = 0;

        repeat (5) nextCycle();
        rstN = 1'b1;
        repeat (2) nextCycle();

        // Whole table in order, no stalls
        strictLatency = 1'b1;
        for (int v = 0; v < 256; v++) begin
            sendByte(gf8_t'(v));
        end
        drain();

        // Same byte under several masks
        for (int b = 0; b < 32; b++) begin
            x = gf8_t'($urandom());
            repeat (8) sendByte(x);
        end
        drain();

        // Back to back burst for latency and throughput
        burstMode = 1'b1;
        repeat (burstCount) sendByte(gf8_t'($urandom()));
        drain();
        burstMode = 1'b0;
        strictLatency = 1'b0;

        // Random gaps on the input, random stalls on the output
        randomReady = 1'b1;
        for (int n = 0; n < bpCount; n++) begin
            while ($urandom_range(99) < 50) begin
                nextCycle();
            end
            sendByte(gf8_t'($urandom()));
        end
        drain();
        randomReady = 1'b0;
        repeat (8) nextCycle();

        $display("Errors: %0d value, %0d protocol", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
